// File: Makefile
TOP := rob_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f

# Pass only when the testbench prints its pass line
run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

// File: rob_asserts.sv
// Concurrent checks on the reorder buffer tail, full flag and commit strobe
`timescale 1ns/1ps
`default_nettype none

module rob_asserts (
  input wire logic              CLK,
  input wire logic              nRST,
  input wire logic              flush,
  input wire logic              full,
  input wire rob_pkg::rob_idx_t cur_tail,
  input wire logic              vreg_wen,
  input wire logic              commit_last
);

  // ==================================================
  // Allocation and commit rules
  // ==================================================
  // Tail stays put while every entry is taken, flush aside
  tail_hold_when_full: assert property (
    @(posedge CLK) disable iff (!nRST)
    (full && !flush) |=> $stable(cur_tail)
  ) else $error("Tail moved while the buffer was full");

  // Flush leaves nothing to commit
  no_commit_after_flush: assert property (
    @(posedge CLK) disable iff (!nRST)
    flush |=> !vreg_wen
  ) else $error("Commit strobe high in the cycle after a flush");

  // Outputs quiet under reset
  quiet_in_reset: assert property (
    @(posedge CLK)
    !nRST |-> (!vreg_wen && !full && !commit_last)
  ) else $error("Commit or full flag active during reset");

endmodule

`default_nettype wire

// File: rob_entry_locator.sv
// Result beat placement: target entry, destination register, byte lane, fill and last status
`timescale 1ns/1ps
`default_nettype none

module rob_entry_locator (
  input  wire rob_pkg::rob_idx_t  res_index,
  input  wire rob_pkg::elem_off_t res_woffset,
  input  wire rob_pkg::vl_t       res_vl,
  input  wire rob_pkg::sew_t      res_sew,
  input  wire rob_pkg::vreg_t     res_vd,
  input  wire logic [1:0]         res_wen,
  output rob_pkg::rob_idx_t       entry_sel,
  output rob_pkg::vreg_t          vd_sel,
  output logic [3:0]              lane_byte,
  output logic                    fill_done,
  output logic                    last_beat,
  output logic [1:0]              elem_wen
);
  import rob_pkg::*;

  // Registers into the group, woffset divided by elements per entry
  elem_off_t  quot;
  // woffset + 2 with headroom for the compare against vl
  logic [8:0] off_plus2;
  // Beat holds only one live element
  logic       odd_tail;

  assign off_plus2 = {2'b00, res_woffset} + 9'd2;
  assign odd_tail  = ({1'b0, res_woffset} + 8'd1) == res_vl;

  // ==================================================
  // Divide and modulo by elements per entry
  // ==================================================
  always_comb begin
    case (res_sew)
      SEW8: begin
        // 16 elements per entry
        quot      = res_woffset >> 4;
        lane_byte = res_woffset[3:0];
        fill_done = (off_plus2[3:0] == 4'd0);
      end
      SEW16: begin
        // 8 elements, 2 bytes each
        quot      = res_woffset >> 3;
        lane_byte = {res_woffset[2:0], 1'b0};
        fill_done = (off_plus2[2:0] == 3'd0);
      end
      default: begin
        // SEW32, 4 elements, 4 bytes each
        quot      = res_woffset >> 2;
        lane_byte = {res_woffset[1:0], 2'b00};
        fill_done = (off_plus2[1:0] == 2'd0);
      end
    endcase
  end

  // Entry index wraps around the buffer
  assign entry_sel = res_index + quot[$bits(rob_idx_t)-1:0];
  assign vd_sel    = res_vd + quot[$bits(vreg_t)-1:0];

  // Final beat once the pair reaches vl
  assign last_beat = off_plus2 >= {1'b0, res_vl};

  // Second element dropped past the end of the vector
  assign elem_wen = {res_wen[1] & ~odd_tail, res_wen[0]};

endmodule

`default_nettype wire

// File: rob_entry_store.sv
// Reorder buffer entry array: beat merge, commit clear, flush and the commit group
`timescale 1ns/1ps
`include "rob_params.svh"
`default_nettype none

module rob_entry_store (
  input  wire logic               CLK,
  input  wire logic               nRST,
  input  wire logic               flush,
  input  wire logic               res_valid,
  input  wire rob_pkg::rob_idx_t  entry_sel,
  input  wire rob_pkg::vreg_t     vd_sel,
  input  wire logic [3:0]         lane_byte,
  input  wire logic               fill_done,
  input  wire logic               last_beat,
  input  wire rob_pkg::sew_t      res_sew,
  input  wire rob_pkg::res_data_t res_wdata,
  input  wire logic [1:0]         res_wen,
  input  wire rob_pkg::rob_idx_t  head_sel,
  input  wire logic               commit_ena,
  output logic                    vreg_wen,
  output rob_pkg::vreg_t          vd_final,
  output rob_pkg::vdata_t         wdata_final,
  output rob_pkg::byte_ena_t      byte_ena_final,
  output logic                    commit_last
);
  import rob_pkg::*;

  localparam int N = `ROB_ENTRIES;

  // Entry fields, current and next
  vdata_t    ent_data  [N];
  byte_ena_t ent_bena  [N];
  vreg_t     ent_vd    [N];
  logic      ent_valid [N];
  logic      ent_last  [N];

  vdata_t    nxt_data  [N];
  byte_ena_t nxt_bena  [N];
  vreg_t     nxt_vd    [N];
  logic      nxt_valid [N];
  logic      nxt_last  [N];

  // Bit offset of the lane inside the entry
  logic [6:0] lane_bit;

  assign lane_bit = {lane_byte, 3'b000};

  // ==================================================
  // Commit group, straight from the head entry
  // ==================================================
  assign vreg_wen       = ent_valid[head_sel] & commit_ena;
  assign vd_final       = ent_vd[head_sel];
  assign wdata_final    = ent_data[head_sel];
  assign byte_ena_final = ent_bena[head_sel];
  assign commit_last    = ent_last[head_sel];

  // ==================================================
  // Next entry state
  // ==================================================
  always_comb begin
    nxt_data  = ent_data;
    nxt_bena  = ent_bena;
    nxt_vd    = ent_vd;
    nxt_valid = ent_valid;
    nxt_last  = ent_last;

    // Retired entry is freed
    if (vreg_wen) begin
      nxt_data[head_sel]  = '0;
      nxt_bena[head_sel]  = '0;
      nxt_vd[head_sel]    = '0;
      nxt_valid[head_sel] = 1'b0;
      nxt_last[head_sel]  = 1'b0;
    end

    // Result beat lands after the clear, so a reused entry keeps it
    if (res_valid) begin
      nxt_vd[entry_sel]    = vd_sel;
      // Valid and last stick until commit, beats may come out of order
      nxt_valid[entry_sel] = nxt_valid[entry_sel] | fill_done | last_beat;
      nxt_last[entry_sel]  = nxt_last[entry_sel] | last_beat;
      case (res_sew)
        SEW32: begin
          // Both words go in whole
          nxt_data[entry_sel][lane_bit +: 64] = res_wdata;
          nxt_bena[entry_sel][lane_byte +: 8] = {{4{res_wen[1]}}, {4{res_wen[0]}}};
        end
        SEW16: begin
          // Low halfword of each word
          nxt_data[entry_sel][lane_bit +: 32] = {res_wdata[47:32], res_wdata[15:0]};
          nxt_bena[entry_sel][lane_byte +: 4] = {{2{res_wen[1]}}, {2{res_wen[0]}}};
        end
        default: begin
          // SEW8, low byte of each word
          nxt_data[entry_sel][lane_bit +: 16] = {res_wdata[39:32], res_wdata[7:0]};
          nxt_bena[entry_sel][lane_byte +: 2] = res_wen;
        end
      endcase
    end
  end

  // ==================================================
  // Entry registers, flush empties everything
  // ==================================================
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < N; i++) begin
        ent_data[i]  <= '0;
        ent_bena[i]  <= '0;
        ent_vd[i]    <= '0;
        ent_valid[i] <= 1'b0;
        ent_last[i]  <= 1'b0;
      end
    end else if (flush) begin
      for (int i = 0; i < N; i++) begin
        ent_data[i]  <= '0;
        ent_bena[i]  <= '0;
        ent_vd[i]    <= '0;
        ent_valid[i] <= 1'b0;
        ent_last[i]  <= 1'b0;
      end
    end else begin
      ent_data  <= nxt_data;
      ent_bena  <= nxt_bena;
      ent_vd    <= nxt_vd;
      ent_valid <= nxt_valid;
      ent_last  <= nxt_last;
    end
  end

endmodule

`default_nettype wire

// File: rob_params.svh
// Reorder buffer sizing macros: entry count, data width, result width, register count
`default_nettype none

`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// Number of reorder buffer entries, power of two
`define ROB_ENTRIES 8

// Bits per entry, same as one vector register
`define ROB_DATA_W 128

// Result beat width, two 32-bit elements
`define ROB_RES_W 64

// Architectural vector registers
`define VREG_COUNT 32

`endif

`default_nettype wire

// File: rob_pkg.sv
// Reorder buffer package: vector typedefs and the SEW and LMUL enums
`include "rob_params.svh"
`default_nettype none

package rob_pkg;

  // ==================================================
  // Element width and register grouping
  // ==================================================
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // Group size sets how far the tail moves per allocation
  typedef enum logic [1:0] {
    LMUL1 = 2'd0,
    LMUL2 = 2'd1,
    LMUL4 = 2'd2
  } lmul_t;

  // ==================================================
  // Vector widths
  // ==================================================
  // Pointer carries one extra wrap bit above the index
  typedef logic [$clog2(`ROB_ENTRIES):0]   rob_ptr_t;
  typedef logic [$clog2(`ROB_ENTRIES)-1:0] rob_idx_t;
  typedef logic [$clog2(`VREG_COUNT)-1:0]  vreg_t;
  typedef logic [`ROB_DATA_W-1:0]          vdata_t;
  // One enable per byte of an entry
  typedef logic [`ROB_DATA_W/8-1:0]        byte_ena_t;
  typedef logic [`ROB_RES_W-1:0]           res_data_t;
  // Element position inside one instruction
  typedef logic [6:0]                      elem_off_t;
  typedef logic [7:0]                      vl_t;

endpackage

`default_nettype wire

// File: rob_pointers.sv
// Reorder buffer head and tail pointers with wrap bit, full flag and flush
`timescale 1ns/1ps
`default_nettype none

module rob_pointers (
  input  wire logic             CLK,
  input  wire logic             nRST,
  input  wire logic             flush,
  input  wire logic             alloc_ena,
  input  wire rob_pkg::lmul_t   lmul,
  input  wire logic             vreg_wen,
  output rob_pkg::rob_idx_t     head_sel,
  output rob_pkg::rob_idx_t     cur_tail,
  output logic                  full
);
  import rob_pkg::*;

  localparam int IDX_W = $bits(rob_idx_t);

  rob_ptr_t head, tail;
  rob_ptr_t next_head, next_tail;
  // Entries claimed by one allocation
  rob_ptr_t step;

  // Index part drives the entry array
  assign head_sel = head[IDX_W-1:0];
  assign cur_tail = tail[IDX_W-1:0];

  // Same index but different lap means every entry is taken
  assign full = (head[IDX_W-1:0] == tail[IDX_W-1:0]) && (head[IDX_W] != tail[IDX_W]);

  // Group size from register grouping
  always_comb begin
    case (lmul)
      LMUL2:   step = rob_ptr_t'(2);
      LMUL4:   step = rob_ptr_t'(4);
      default: step = rob_ptr_t'(1);
    endcase
  end

  // ==================================================
  // Next pointer values, flush has priority
  // ==================================================
  always_comb begin
    next_head = head;
    next_tail = tail;
    if (flush) begin
      next_head = '0;
      next_tail = '0;
    end else begin
      // One entry retires per commit
      if (vreg_wen) begin
        next_head = head + rob_ptr_t'(1);
      end
      // Allocation ignored while full
      if (alloc_ena && !full) begin
        next_tail = tail + step;
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head <= '0;
      tail <= '0;
    end else begin
      head <= next_head;
      tail <= next_tail;
    end
  end

endmodule

`default_nettype wire

// File: rob_stimulus.txt
# alloc lmul exp_tail exp_full | result index woff vl sew vd data wen
# commit exp_wen vd data byte_ena last | flush | idle | test name (fields in hex)
test t1_lmul1_sew32
alloc 0 0 0
result 0 00 04 2 03 2222222211111111 3
commit 0 00 0 0000 0
result 0 02 04 2 03 4444444433333333 3
commit 1 03 44444444333333332222222211111111 ffff 1
test t2_sew8_odd_tail
alloc 0 1 0
result 1 00 03 0 05 000000b2000000a1 3
result 1 02 03 0 05 000000d4000000c3 3
commit 1 05 d4c3b2a1 0007 1
test t4_wen_cleared
alloc 0 2 0
result 2 00 02 1 07 0000beef0000cafe 1
commit 1 07 beefcafe 0003 1
test t3_lmul2_out_of_order
alloc 1 3 0
result 3 08 10 1 0a 0000a0090000a008 3
result 3 0c 10 1 0a 0000a00d0000a00c 3
result 3 0e 10 1 0a 0000a00f0000a00e 3
result 3 0a 10 1 0a 0000a00b0000a00a 3
commit 0 00 0 0000 0
result 3 06 10 1 0a 0000a0070000a006 3
result 3 00 10 1 0a 0000a0010000a000 3
result 3 04 10 1 0a 0000a0050000a004 3
result 3 02 10 1 0a 0000a0030000a002 3
commit 1 0a a007a006a005a004a003a002a001a000 ffff 0
commit 1 0b a00fa00ea00da00ca00ba00aa009a008 ffff 1
test t5_full
alloc 2 5 0
alloc 2 1 0
alloc 0 5 1
alloc 0 5 1
result 5 02 10 2 14 3333000322220002 3
commit 1 14 33330003222200020000000000000000 ff00 0
alloc 0 5 0
test t6_flush
result 5 06 10 2 14 7777000766660006 3
result 5 0e 10 2 14 ffff000feeee000e 3
idle
flush
commit 0 00 0 0000 0
alloc 0 0 0
result 0 00 02 2 01 0badf00d12345678 3
commit 1 01 0badf00d12345678 00ff 1

// File: rob_tb.sv
// Reorder buffer testbench with stimulus file reader, DUT drive, allocation and commit checks
`timescale 1ns/1ps
`default_nettype none

module rob_tb;
  import rob_pkg::*;

  localparam string STIM_FILE = "rob_stimulus.txt";

  // DUT inputs
  logic       CLK;
  logic       nRST;
  logic       alloc_ena;
  lmul_t      lmul;
  logic       res_valid;
  rob_idx_t   res_index;
  elem_off_t  res_woffset;
  vl_t        res_vl;
  sew_t       res_sew;
  vreg_t      res_vd;
  res_data_t  res_wdata;
  logic [1:0] res_wen;
  logic       commit_ena;
  logic       flush;

  // DUT outputs
  rob_idx_t   cur_tail;
  logic       full;
  logic       vreg_wen;
  vreg_t      vd_final;
  vdata_t     wdata_final;
  byte_ena_t  byte_ena_final;
  logic       commit_last;

  // Run bookkeeping
  int unsigned     cycle_cnt = 0;
  int unsigned     cycle_limit = 1000;
  int unsigned     commit_cnt = 0;
  logic [8*32-1:0] test_name;

  rob_top uut (.*);

  bind rob_top rob_asserts u_asserts (
    .CLK         (CLK),
    .nRST        (nRST),
    .flush       (flush),
    .full        (full),
    .cur_tail    (cur_tail),
    .vreg_wen    (vreg_wen),
    .commit_last (commit_last)
  );

  // 20 ns period
  always #10 CLK = ~CLK;

  // ==================================================
  // Failure handling and compare tasks
  // ==================================================
  task automatic abort_run;
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic report_bad_line(input string line);
    $display("Stimulus line could not be parsed: %0s", line);
    abort_run();
  endtask

  task automatic check_vreg(input string what, input vreg_t exp, input vreg_t act);
    if (exp !== act) begin
      $display("ERR %0s %0s expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_vdata(input string what, input vdata_t exp, input vdata_t act);
    if (exp !== act) begin
      $display("ERR %0s %0s expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_byte_ena(input string what, input byte_ena_t exp, input byte_ena_t act);
    if (exp !== act) begin
      $display("ERR %0s %0s expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_idx(input string what, input rob_idx_t exp, input rob_idx_t act);
    if (exp !== act) begin
      $display("ERR %0s %0s expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR %0s %0s expected %b actual %b", test_name, what, exp, act);
      abort_run();
    end
  endtask

  // All strobes low and levels parked
  task automatic idle_inputs;
    alloc_ena   = 1'b0;
    lmul        = LMUL1;
    res_valid   = 1'b0;
    res_index   = '0;
    res_woffset = '0;
    res_vl      = '0;
    res_sew     = SEW8;
    res_vd      = '0;
    res_wdata   = '0;
    res_wen     = '0;
    commit_ena  = 1'b0;
    flush       = 1'b0;
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic start_cycle;
    @(posedge CLK);
    #2;
    idle_inputs();
  endtask

  // Run limit set from the stimulus length
  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: stimulus still running after %0d cycles", cycle_cnt);
      abort_run();
    end
  end

  // ==================================================
  // Stimulus loop
  // ==================================================
  initial begin
    int              fd;
    int              lines;
    string           line;
    logic [8*16-1:0] cmd;
    logic [1:0]      f_lmul;
    logic [1:0]      f_sew;
    rob_idx_t        f_idx;
    elem_off_t       f_woff;
    vl_t             f_vl;
    vreg_t           f_vd;
    res_data_t       f_wdata;
    logic [1:0]      f_wen;
    logic            f_bit;
    logic            f_last;
    vdata_t          f_data;
    byte_ena_t       f_bena;

    CLK = 1'b0;
    nRST = 1'b0;
    idle_inputs();
    // Commit enable held high through reset against an empty head
    commit_ena = 1'b1;
    test_name = "reset";
    lines = 0;

    // First pass only sizes the timeout
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %0s", STIM_FILE);
      abort_run();
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) != 0) begin
        lines++;
      end
    end
    $fclose(fd);
    cycle_limit = 40 + 4 * lines;

    repeat (10) @(posedge CLK);
    #2;
    nRST = 1'b1;
    commit_ena = 1'b0;

    fd = $fopen(STIM_FILE, "r");
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) begin
        continue;
      end
      // Blank lines and comment lines use no cycle
      if ($sscanf(line, "%s", cmd) < 1 || cmd == "#") begin
        continue;
      end
      if (cmd == "test") begin
        void'($sscanf(line, "%s %s", cmd, test_name));
      end else if (cmd == "alloc") begin
        if ($sscanf(line, "%s %h %h %h", cmd, f_lmul, f_idx, f_bit) != 4) begin
          report_bad_line(line);
        end
        start_cycle();
        alloc_ena = 1'b1;
        lmul      = lmul_t'(f_lmul);
        // cur_tail still shows the index before the move
        #8;
        check_idx("cur_tail", f_idx, cur_tail);
        check_bit("full", f_bit, full);
      end else if (cmd == "result") begin
        if ($sscanf(line, "%s %h %h %h %h %h %h %h", cmd, f_idx, f_woff, f_vl, f_sew,
                    f_vd, f_wdata, f_wen) != 8) begin
          report_bad_line(line);
        end
        start_cycle();
        res_valid   = 1'b1;
        res_index   = f_idx;
        res_woffset = f_woff;
        res_vl      = f_vl;
        res_sew     = sew_t'(f_sew);
        res_vd      = f_vd;
        res_wdata   = f_wdata;
        res_wen     = f_wen;
      end else if (cmd == "commit") begin
        if ($sscanf(line, "%s %h %h %h %h %h", cmd, f_bit, f_vd, f_data, f_bena,
                    f_last) != 6) begin
          report_bad_line(line);
        end
        start_cycle();
        commit_ena = 1'b1;
        // Commit group is combinational and is sampled mid cycle
        #8;
        check_bit("vreg_wen", f_bit, vreg_wen);
        if (f_bit) begin
          check_vreg("vd_final", f_vd, vd_final);
          check_vdata("wdata_final", f_data, wdata_final);
          check_byte_ena("byte_ena_final", f_bena, byte_ena_final);
          check_bit("commit_last", f_last, commit_last);
          commit_cnt++;
        end
      end else if (cmd == "flush") begin
        start_cycle();
        flush = 1'b1;
      end else if (cmd == "idle") begin
        start_cycle();
      end else begin
        report_bad_line(line);
      end
    end
    $fclose(fd);

    // Release the last strobe
    start_cycle();
    if (commit_cnt == 0) begin
      $display("No commit was checked, the stimulus file holds no commit");
      abort_run();
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: rob_top.sv
// Vector reorder buffer top level: pointers, beat locator and entry store
`timescale 1ns/1ps
`default_nettype none

module rob_top (
  input  wire logic               CLK,
  input  wire logic               nRST,
  // Allocation
  input  wire logic               alloc_ena,
  input  wire rob_pkg::lmul_t     lmul,
  // Result beat
  input  wire logic               res_valid,
  input  wire rob_pkg::rob_idx_t  res_index,
  input  wire rob_pkg::elem_off_t res_woffset,
  input  wire rob_pkg::vl_t       res_vl,
  input  wire rob_pkg::sew_t      res_sew,
  input  wire rob_pkg::vreg_t     res_vd,
  input  wire rob_pkg::res_data_t res_wdata,
  input  wire logic [1:0]         res_wen,
  // Control
  input  wire logic               commit_ena,
  input  wire logic               flush,
  // Allocation status
  output rob_pkg::rob_idx_t       cur_tail,
  output logic                    full,
  // Commit group toward the register file
  output logic                    vreg_wen,
  output rob_pkg::vreg_t          vd_final,
  output rob_pkg::vdata_t         wdata_final,
  output rob_pkg::byte_ena_t      byte_ena_final,
  output logic                    commit_last
);
  import rob_pkg::*;

  // Placement of the current beat
  rob_idx_t   entry_sel;
  vreg_t      vd_sel;
  logic [3:0] lane_byte;
  logic       fill_done;
  logic       last_beat;
  logic [1:0] elem_wen;
  rob_idx_t   head_sel;

  // ==================================================
  // Head and tail
  // ==================================================
  rob_pointers u_pointers (
    .CLK       (CLK),
    .nRST      (nRST),
    .flush     (flush),
    .alloc_ena (alloc_ena),
    .lmul      (lmul),
    .vreg_wen  (vreg_wen),
    .head_sel  (head_sel),
    .cur_tail  (cur_tail),
    .full      (full)
  );

  rob_entry_locator u_locator (
    .res_index   (res_index),
    .res_woffset (res_woffset),
    .res_vl      (res_vl),
    .res_sew     (res_sew),
    .res_vd      (res_vd),
    .res_wen     (res_wen),
    .entry_sel   (entry_sel),
    .vd_sel      (vd_sel),
    .lane_byte   (lane_byte),
    .fill_done   (fill_done),
    .last_beat   (last_beat),
    .elem_wen    (elem_wen)
  );

  // Store sees enables already trimmed at the vector end
  rob_entry_store u_store (
    .CLK            (CLK),
    .nRST           (nRST),
    .flush          (flush),
    .res_valid      (res_valid),
    .entry_sel      (entry_sel),
    .vd_sel         (vd_sel),
    .lane_byte      (lane_byte),
    .fill_done      (fill_done),
    .last_beat      (last_beat),
    .res_sew        (res_sew),
    .res_wdata      (res_wdata),
    .res_wen        (elem_wen),
    .head_sel       (head_sel),
    .commit_ena     (commit_ena),
    .vreg_wen       (vreg_wen),
    .vd_final       (vd_final),
    .wdata_final    (wdata_final),
    .byte_ena_final (byte_ena_final),
    .commit_last    (commit_last)
  );

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
rob_pkg.sv
rob_pointers.sv
rob_entry_locator.sv
rob_entry_store.sv
rob_top.sv
rob_asserts.sv
rob_tb.sv
